//--- source/core_settings.svh
// Build constants shared by the packages and the pipeline stages
// XLEN other than 32 is not supported by the immediate and opcode layout
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width
`define CORE_XLEN 32

// Integer register file
`define CORE_NUM_REGS 32
`define CORE_REG_AW 5

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- source/rv_isa_pkg.sv
// RV32I subset encodings: ADD SUB AND OR SLT ADDI LW SW BEQ
// Other opcodes decode to a no-op
package rv_isa_pkg;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    // Operations the ALU can run
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } alu_op_e;

    // funct3 field values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Only the equal condition is decoded
    localparam logic [2:0] F3_BEQ     = 3'b000;

    // funct7 pattern that turns ADD into SUB
    localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

//--- source/core_pipe_pkg.sv
// Records carried between the pipeline stages and on the core ports
// Field widths follow the core build constants
`include "core_settings.svh"

package core_pipe_pkg;

    // Decoded control, travels with the instruction
    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        logic                alu_src_imm;
        logic                mem_read;
        logic                mem_write;
        logic                reg_write;
        logic                mem_to_reg;
        logic                branch;
    } ctrl_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_XLEN-1:0]   rs1_data;
        logic [`CORE_XLEN-1:0]   rs2_data;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        ctrl_t                   ctrl;
        logic [`CORE_XLEN-1:0]   alu_result;
        logic [`CORE_XLEN-1:0]   store_data;
        logic [`CORE_REG_AW-1:0] rd;
    } ex_mem_t;

    // Register write, also the retire report
    typedef struct packed {
        logic                    valid;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
        logic                  we;
        logic                  re;
    } dmem_req_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        REG      = 2'd0,
        FROM_MEM = 2'd1,
        FROM_WB  = 2'd2
    } fwd_sel_e;

endpackage

//--- source/fetch_stage.sv
// Instruction fetch and the IF/ID register
// The instruction port must answer in the same cycle
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  branch_taken,
    input  logic [`CORE_XLEN-1:0] branch_target,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0] imem_instr,
    output logic [`CORE_XLEN-1:0] if_pc,
    output logic [`CORE_XLEN-1:0] if_instr,
    output logic                  if_valid
);

    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pc_plus4;

    assign pc_plus4  = pc + `CORE_XLEN'(4);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `CORE_RESET_PC;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            // Redirect, the instruction now in flight is dropped
            pc       <= branch_target;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc_plus4;
            if_valid <= 1'b1;
        end
    end

    // IF/ID payload, held while stalled
    always_ff @(posedge clk) begin
        if (!stall || branch_taken) begin
            if_pc    <= pc;
            if_instr <= imem_instr;
        end
    end

endmodule

//--- source/decode_stage.sv
// Decode, register bank, immediates, load-use detection and ID/EX register
// A read in the same cycle as a write to that register sees the new value
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CORE_XLEN-1:0] if_pc,
    input  logic [`CORE_XLEN-1:0] if_instr,
    input  logic                  if_valid,
    input  logic                  branch_taken,
    input  core_pipe_pkg::wb_t    wb,
    output logic                  stall,
    output core_pipe_pkg::id_ex_t id_ex
);

    rv_isa_pkg::opcode_e     opcode;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    core_pipe_pkg::ctrl_t    ctrl;
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_XLEN-1:0]   regs [`CORE_NUM_REGS];

    assign opcode = rv_isa_pkg::opcode_e'(if_instr[6:0]);
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    // Main control and ALU control
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_isa_pkg::ADD;
        case (opcode)
            rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: begin
                ctrl.alu_src_imm = (opcode == rv_isa_pkg::OP_IMM);
                ctrl.reg_write   = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        if (opcode == rv_isa_pkg::OP && if_instr[31:25] == rv_isa_pkg::F7_SUB)
                            ctrl.alu_op = rv_isa_pkg::SUB;
                    end
                    rv_isa_pkg::F3_SLT: ctrl.alu_op = rv_isa_pkg::SLT;
                    rv_isa_pkg::F3_OR:  ctrl.alu_op = rv_isa_pkg::OR;
                    rv_isa_pkg::F3_AND: ctrl.alu_op = rv_isa_pkg::AND;
                    default: ;
                endcase
            end
            rv_isa_pkg::LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            rv_isa_pkg::STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            rv_isa_pkg::BRANCH: ctrl.branch = (funct3 == rv_isa_pkg::F3_BEQ);
            default: ;
        endcase
        if (!if_valid)
            ctrl = '0;
    end

    // I, S and B immediates
    always_comb begin
        case (opcode)
            rv_isa_pkg::STORE:
                imm = {{(`CORE_XLEN-12){if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            rv_isa_pkg::BRANCH:
                imm = {{(`CORE_XLEN-13){if_instr[31]}}, if_instr[31], if_instr[7],
                       if_instr[30:25], if_instr[11:8], 1'b0};
            default:
                imm = {{(`CORE_XLEN-12){if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

    // x0 reads zero, a pending writeback bypasses the bank
    function automatic logic [`CORE_XLEN-1:0] read_reg(input logic [`CORE_REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb.valid && wb.rd == addr)
            return wb.data;
        return regs[addr];
    endfunction

    // Load in EX feeding this instruction
    assign stall = if_valid && id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                   (id_ex.rd == rs1 || id_ex.rd == rs2);

    always_ff @(posedge clk) begin
        id_ex.pc       <= if_pc;
        id_ex.rs1_data <= read_reg(rs1);
        id_ex.rs2_data <= read_reg(rs2);
        id_ex.imm      <= imm;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rd       <= if_instr[11:7];
        // Bubble on load-use or a taken branch
        if (!rst_n || stall || branch_taken) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid <= if_valid;
            id_ex.ctrl  <= ctrl;
        end
    end

endmodule

//--- source/execute_stage.sv
// Operand forwarding, ALU, BEQ resolution and the EX/MEM register
// A load result is never forwarded from MEM, decode stalls instead
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pipe_pkg::id_ex_t  id_ex,
    input  core_pipe_pkg::wb_t     wb,
    output core_pipe_pkg::ex_mem_t ex_mem_fwd,
    output logic                   branch_taken,
    output logic [`CORE_XLEN-1:0]  branch_target
);

    core_pipe_pkg::fwd_sel_e fwd_a;
    core_pipe_pkg::fwd_sel_e fwd_b;
    logic [`CORE_XLEN-1:0]   op_a;
    logic [`CORE_XLEN-1:0]   rs2_val;
    logic [`CORE_XLEN-1:0]   op_b;
    logic [`CORE_XLEN-1:0]   alu_result;

    // Youngest producer wins, x0 is never forwarded
    function automatic core_pipe_pkg::fwd_sel_e fwd_pick(input logic [`CORE_REG_AW-1:0] rs);
        if (rs == '0)
            return core_pipe_pkg::REG;
        if (ex_mem_fwd.valid && ex_mem_fwd.ctrl.reg_write && ex_mem_fwd.rd == rs)
            return core_pipe_pkg::FROM_MEM;
        if (wb.valid && wb.rd == rs)
            return core_pipe_pkg::FROM_WB;
        return core_pipe_pkg::REG;
    endfunction

    function automatic logic [`CORE_XLEN-1:0] fwd_mux(input core_pipe_pkg::fwd_sel_e sel,
                                                       input logic [`CORE_XLEN-1:0] reg_val);
        case (sel)
            core_pipe_pkg::FROM_MEM: return ex_mem_fwd.alu_result;
            core_pipe_pkg::FROM_WB:  return wb.data;
            default:                 return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a   = fwd_pick(id_ex.rs1);
        fwd_b   = fwd_pick(id_ex.rs2);
        op_a    = fwd_mux(fwd_a, id_ex.rs1_data);
        rs2_val = fwd_mux(fwd_b, id_ex.rs2_data);
        op_b    = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            rv_isa_pkg::ADD: alu_result = op_a + op_b;
            rv_isa_pkg::SUB: alu_result = op_a - op_b;
            rv_isa_pkg::AND: alu_result = op_a & op_b;
            rv_isa_pkg::OR:  alu_result = op_a | op_b;
            rv_isa_pkg::SLT: alu_result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:         alu_result = '0;
        endcase
    end

    // BEQ compares the forwarded register values
    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch && (op_a == rs2_val);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        ex_mem_fwd.alu_result <= alu_result;
        ex_mem_fwd.store_data <= rs2_val;
        ex_mem_fwd.rd         <= id_ex.rd;
        if (!rst_n) begin
            ex_mem_fwd.valid <= 1'b0;
            ex_mem_fwd.ctrl  <= '0;
        end else begin
            ex_mem_fwd.valid <= id_ex.valid;
            ex_mem_fwd.ctrl  <= id_ex.ctrl;
        end
    end

endmodule

//--- source/memory_stage.sv
// Data port request, writeback select and the MEM/WB register
// Load data must arrive in the same cycle as the request
`timescale 1ns/1ps
`include "core_settings.svh"

module memory_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pipe_pkg::ex_mem_t    ex_mem,
    output core_pipe_pkg::dmem_req_t  dmem_req,
    input  logic [`CORE_XLEN-1:0]     dmem_rdata,
    output core_pipe_pkg::wb_t        wb
);

    logic [`CORE_XLEN-1:0] wb_data;

    // Request straight from EX/MEM
    always_comb begin
        dmem_req.addr  = ex_mem.alu_result;
        dmem_req.wdata = ex_mem.store_data;
        dmem_req.we    = ex_mem.valid && ex_mem.ctrl.mem_write;
        dmem_req.re    = ex_mem.valid && ex_mem.ctrl.mem_read;
    end

    // Writeback select
    assign wb_data = ex_mem.ctrl.mem_to_reg ? dmem_rdata : ex_mem.alu_result;

    // MEM/WB, its output is the register write and the retire report
    always_ff @(posedge clk) begin
        wb.rd   <= ex_mem.rd;
        wb.data <= wb_data;
        if (!rst_n)
            wb.valid <= 1'b0;
        else
            wb.valid <= ex_mem.valid && ex_mem.ctrl.reg_write;
    end

endmodule

//--- source/segmented_core.sv
// Five-stage RV32I subset core, instruction and data memories sit outside
// Both ports read combinationally, data writes land on the clock edge
`timescale 1ns/1ps
`include "core_settings.svh"

module segmented_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [`CORE_XLEN-1:0]    imem_addr,
    input  logic [`CORE_XLEN-1:0]    imem_instr,
    output core_pipe_pkg::dmem_req_t dmem_req,
    input  logic [`CORE_XLEN-1:0]    dmem_rdata,
    output core_pipe_pkg::wb_t       retire
);

    logic [`CORE_XLEN-1:0]  if_pc;
    logic [`CORE_XLEN-1:0]  if_instr;
    logic                   if_valid;
    logic                   stall;
    logic                   branch_taken;
    logic [`CORE_XLEN-1:0]  branch_target;
    core_pipe_pkg::id_ex_t  id_ex;
    core_pipe_pkg::ex_mem_t ex_mem;
    core_pipe_pkg::wb_t     wb;

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_instr    (imem_instr),
        .if_pc         (if_pc),
        .if_instr      (if_instr),
        .if_valid      (if_valid)
    );

    decode_stage i_decode_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_pc        (if_pc),
        .if_instr     (if_instr),
        .if_valid     (if_valid),
        .branch_taken (branch_taken),
        .wb           (wb),
        .stall        (stall),
        .id_ex        (id_ex)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .wb            (wb),
        .ex_mem_fwd    (ex_mem),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage i_memory_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    // Every register write is reported
    assign retire = wb;

endmodule

//--- tb/segmented_core_assert.sv
// Checks on the segmented_core ports, active once reset is released
// rst_n is taken as synchronous and sampled on the rising edge
`timescale 1ns/1ps
`include "core_settings.svh"

module segmented_core_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`CORE_XLEN-1:0]    imem_addr,
    input core_pipe_pkg::dmem_req_t dmem_req,
    input core_pipe_pkg::wb_t       retire
);

    int failures = 0;

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00)
    else begin
        $error("imem_addr %h is not word aligned", imem_addr);
        failures++;
    end

    // A single data access per cycle
    dmem_one_access: assert property (@(posedge clk) disable iff (!rst_n)
                                      !(dmem_req.we && dmem_req.re))
    else begin
        $error("dmem_req has we and re high together");
        failures++;
    end

    retire_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(retire.valid))
    else begin
        $error("retire.valid is unknown");
        failures++;
    end

    // Nothing can have reached writeback yet
    retire_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !retire.valid)
    else begin
        $error("retire.valid high in the first cycle after reset");
        failures++;
    end

endmodule

bind segmented_core segmented_core_assert i_segmented_core_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req),
    .retire    (retire)
);

//--- tb/segmented_core_tb.sv
// Testbench for segmented_core with instruction and data memory models
// Programs branch forward only and end in a BEQ self loop, so nothing retires after them
`timescale 1ns/1ps
`include "core_settings.svh"

module segmented_core_tb;

    localparam int                    MEM_WORDS = 64;
    localparam logic [`CORE_XLEN-1:0] NOP       = 32'h0000_0013;
    localparam logic [2:0]            F3_ADD    = 3'b000;
    localparam logic [2:0]            F3_SLT    = 3'b010;
    localparam logic [2:0]            F3_OR     = 3'b110;
    localparam logic [2:0]            F3_AND    = 3'b111;
    localparam logic [6:0]            F7_SUB    = 7'b0100000;

    logic                     clk;
    logic                     rst_n;
    logic [`CORE_XLEN-1:0]    imem_addr;
    logic [`CORE_XLEN-1:0]    imem_instr;
    core_pipe_pkg::dmem_req_t dmem_req;
    logic [`CORE_XLEN-1:0]    dmem_rdata;
    core_pipe_pkg::wb_t       retire;

    logic [`CORE_XLEN-1:0] imem [MEM_WORDS];
    logic [`CORE_XLEN-1:0] dmem [MEM_WORDS];
    // Architectural state as the ISA rules predict it
    logic [`CORE_XLEN-1:0] ref_regs [`CORE_NUM_REGS];
    logic [`CORE_XLEN-1:0] ref_dmem [MEM_WORDS];
    // Pending retires as {rd, value}, pending stores as {addr, data}
    logic [`CORE_REG_AW+`CORE_XLEN-1:0] retires_due [$];
    logic [2*`CORE_XLEN-1:0]            stores_due [$];
    int   pc_words;
    int   skip_to;
    logic live;
    int   errors;
    int   passed;
    int   failed;
    int   total_instr;
    int   tests_run;
    int   assert_base;

    segmented_core i_segmented_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_instr (imem_instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign imem_instr = imem[imem_addr[7:2]];
    // Read data only while a load is requested
    assign dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[7:2]] : '0;

    always @(posedge clk) begin
        if (dmem_req.we)
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
    end

    // Scoreboard, sampled mid-cycle
    always @(negedge clk) begin : scoreboard
        logic [`CORE_REG_AW+`CORE_XLEN-1:0] want_retire;
        logic [2*`CORE_XLEN-1:0]            want_store;
        if (rst_n && retire.valid) begin
            assert (retires_due.size() != 0) else begin
                $display("Unexpected retire of x%0d at %0t ns", retire.rd, $time);
                errors++;
            end
            if (retires_due.size() != 0) begin
                want_retire = retires_due.pop_front();
                assert ({retire.rd, retire.data} == want_retire) else begin
                    $display("Error at %0t ns: retire expected x%0d = %h, got x%0d = %h", $time,
                             want_retire[`CORE_XLEN +: `CORE_REG_AW],
                             want_retire[`CORE_XLEN-1:0], retire.rd, retire.data);
                    errors++;
                end
            end
        end
        if (rst_n && dmem_req.we) begin
            assert (stores_due.size() != 0) else begin
                $display("Unexpected store to %h at %0t ns", dmem_req.addr, $time);
                errors++;
            end
            if (stores_due.size() != 0) begin
                want_store = stores_due.pop_front();
                assert ({dmem_req.addr, dmem_req.wdata} == want_store) else begin
                    $display("Error at %0t ns: store expected [%h] = %h, got [%h] = %h", $time,
                             want_store[2*`CORE_XLEN-1:`CORE_XLEN], want_store[`CORE_XLEN-1:0],
                             dmem_req.addr, dmem_req.wdata);
                    errors++;
                end
            end
        end
    end

    // OP and OP-IMM result by funct fields
    function automatic logic [`CORE_XLEN-1:0] isa_result(input logic [2:0] f3,
                                                          input logic sub,
                                                          input logic [`CORE_XLEN-1:0] a,
                                                          input logic [`CORE_XLEN-1:0] b);
        case (f3)
            F3_SLT:  return `CORE_XLEN'($signed(a) < $signed(b));
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    // Slots inside a taken branch's shadow leave the reference untouched
    task automatic put_word(input logic [`CORE_XLEN-1:0] word);
        live = (pc_words >= skip_to);
        imem[pc_words] = word;
        pc_words++;
        total_instr++;
    endtask

    task automatic note_write(input int rd, input logic [`CORE_XLEN-1:0] value);
        if (live) begin
            retires_due.push_back({5'(rd), value});
            if (rd != 0)
                ref_regs[rd] = value;
        end
    endtask

    task automatic rtype(input logic [6:0] f7, input logic [2:0] f3,
                         input int rd, input int rs1, input int rs2);
        put_word({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
        note_write(rd, isa_result(f3, f7[5], ref_regs[rs1], ref_regs[rs2]));
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        put_word({12'(imm), 5'(rs1), F3_ADD, 5'(rd), 7'b0010011});
        note_write(rd, isa_result(F3_ADD, 1'b0, ref_regs[rs1], 32'(imm)));
    endtask

    task automatic lw(input int rd, input int rs1, input int imm);
        logic [`CORE_XLEN-1:0] addr;
        put_word({12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
        addr = ref_regs[rs1] + 32'(imm);
        note_write(rd, ref_dmem[addr[7:2]]);
    endtask

    task automatic sw(input int rs2, input int rs1, input int imm);
        logic [11:0]           off;
        logic [`CORE_XLEN-1:0] addr;
        off = 12'(imm);
        put_word({off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011});
        addr = ref_regs[rs1] + 32'(imm);
        if (live) begin
            ref_dmem[addr[7:2]] = ref_regs[rs2];
            stores_due.push_back({addr, ref_regs[rs2]});
        end
    endtask

    task automatic beq(input int rs1, input int rs2, input int offset);
        logic [12:0] off;
        off = 13'(offset);
        put_word({off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], 7'b1100011});
        if (live && ref_regs[rs1] == ref_regs[rs2])
            skip_to = pc_words - 1 + offset / 4;
    endtask

    // Holds the core in reset while a new program is loaded
    task automatic begin_test();
        int i;
        tests_run++;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        for (i = 0; i < MEM_WORDS; i++)
            imem[i] = NOP;
        pc_words = 0;
        skip_to = 0;
        errors = 0;
        assert_base = i_segmented_core.i_segmented_core_assert.failures;
        retires_due.delete();
        stores_due.delete();
    endtask

    task automatic finish_test(input string name);
        beq(0, 0, 0);
        repeat (15) begin
            @(negedge clk);
            assert (!retire.valid && !dmem_req.we) else begin
                $display("Retire or store strobe seen at %0t ns while reset is held", $time);
                errors++;
            end
            @(posedge clk);
        end
        rst_n <= 1'b1;
        @(negedge clk);
        assert (imem_addr == `CORE_RESET_PC) else begin
            $display("Error at %0t ns: first fetch address %h, expected %h", $time,
                     imem_addr, `CORE_RESET_PC);
            errors++;
        end
        while (retires_due.size() != 0 || stores_due.size() != 0)
            @(posedge clk);
        // Room for a stray retire to show up
        repeat (8) @(posedge clk);
        errors += i_segmented_core.i_segmented_core_assert.failures - assert_base;
        if (errors == 0) begin
            passed++;
            $display("Test %s passed", name);
        end else begin
            failed++;
            $display("Test %s failed with %0d errors", name, errors);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 40 * total_instr + 32 * tests_run) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: expected retires did not arrive within %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int i;
        rst_n = 1'b0;
        void'($urandom(32'h5575));
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = NOP;
            dmem[i] = $urandom();
            ref_dmem[i] = dmem[i];
        end
        for (i = 0; i < `CORE_NUM_REGS; i++)
            ref_regs[i] = '0;

        // Dependent chain, operands from MEM and WB
        begin_test();
        addi(1, 0, 7);
        addi(2, 1, -3);
        rtype(7'b0, F3_ADD, 3, 1, 2);
        rtype(F7_SUB, F3_ADD, 4, 3, 1);
        rtype(7'b0, F3_AND, 5, 4, 3);
        rtype(7'b0, F3_OR, 6, 5, 4);
        rtype(F7_SUB, F3_ADD, 7, 2, 3);
        rtype(7'b0, F3_SLT, 8, 7, 2);
        rtype(7'b0, F3_SLT, 9, 2, 7);
        addi(0, 1, 5);
        rtype(7'b0, F3_ADD, 10, 0, 1);
        finish_test("alu_chain");

        begin_test();
        addi(1, 0, 64);
        addi(2, 0, 291);
        sw(2, 1, 0);
        sw(1, 1, 8);
        lw(3, 1, 0);
        lw(4, 1, 8);
        // Word 10 still holds its random fill
        lw(5, 0, 40);
        rtype(7'b0, F3_ADD, 6, 3, 4);
        finish_test("store_load");

        begin_test();
        addi(1, 0, 32);
        addi(2, 0, 1000);
        sw(2, 1, 4);
        lw(3, 1, 4);
        rtype(7'b0, F3_ADD, 4, 3, 2);
        lw(5, 0, 0);
        rtype(F7_SUB, F3_ADD, 6, 4, 5);
        finish_test("load_use");

        begin_test();
        addi(1, 0, 5);
        addi(2, 0, 5);
        beq(1, 2, 12);
        addi(3, 0, 1);
        addi(4, 0, 2);
        addi(5, 1, 10);
        beq(5, 1, 8);
        addi(6, 0, 3);
        addi(7, 5, 1);
        finish_test("branches");

        $display("Tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+source
source/rv_isa_pkg.sv
source/core_pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/segmented_core.sv
tb/segmented_core_assert.sv
tb/segmented_core_tb.sv

//--- Bender.yml
package:
  name: segmented_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/core_pipe_pkg.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/segmented_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/segmented_core_assert.sv
      - tb/segmented_core_tb.sv
